// ==== verilog/platform_pkg.sv ====
package platform_pkg;

    ////////////////////
    // bus widths
    localparam int DATA_W  = 32;
    localparam int ADDR_W  = 32;
    localparam int BE_W    = 4;
    localparam int OFFS_W  = 4;     // register offset bits seen by a slave
    localparam int MTIME_W = 64;

    ////////////////////
    // interrupt sources
    localparam int IRQ_COUNT   = 2;
    localparam int IRQ_ID_W    = 2; // id 0 means no source
    localparam int IRQ_SRC_BTN = 1;
    localparam int IRQ_SRC_SW  = 2;

    ////////////////////
    // address map, decoded on the upper nibble
    typedef enum logic [1:0] {
        NONE,
        RTC,
        PLIC,
        PERIPH
    } region_e;

    localparam logic [3:0] REGION_NONE_TOP = 4'h2;  // ram region, not present
    localparam logic [3:0] REGION_RTC_TOP  = 4'h3;
    localparam logic [3:0] REGION_PLIC_TOP = 4'h8;

    localparam logic [ADDR_W-1:0] RTC_BASE    = 32'h2000_0000;
    localparam logic [ADDR_W-1:0] PLIC_BASE   = 32'h3000_0000;
    localparam logic [ADDR_W-1:0] PERIPH_BASE = 32'h8000_0000;

    // timer registers
    localparam logic [OFFS_W-1:0] MT_MTIME_LO = 4'h0;
    localparam logic [OFFS_W-1:0] MT_MTIME_HI = 4'h4;
    localparam logic [OFFS_W-1:0] MT_CMP_LO   = 4'h8;
    localparam logic [OFFS_W-1:0] MT_CMP_HI   = 4'hC;

    // plic registers
    localparam logic [OFFS_W-1:0] PL_PENDING = 4'h0;
    localparam logic [OFFS_W-1:0] PL_ENABLE  = 4'h4;
    localparam logic [OFFS_W-1:0] PL_CLAIM   = 4'h8;

    // event peripheral registers
    localparam logic [OFFS_W-1:0] EV_COUNT   = 4'h0;
    localparam logic [OFFS_W-1:0] EV_SCRATCH = 4'h4;
    localparam logic [OFFS_W-1:0] EV_SWIRQ   = 4'h8;

    // byte lane merge for partial writes
    function automatic logic [DATA_W-1:0] be_merge(
        input logic [DATA_W-1:0] old_word,
        input logic [DATA_W-1:0] new_word,
        input logic [BE_W-1:0]   be
    );
        logic [DATA_W-1:0] res;
        res = old_word;
        for (int b = 0; b < BE_W; b++) begin
            if (be[b]) begin
                res[8*b +: 8] = new_word[8*b +: 8];
            end
        end
        return res;
    endfunction

endpackage

// ==== verilog/bus_decoder.sv ====
module bus_decoder (
    input  logic                              clk,
    input  logic                              rst_n_i,
    input  logic                              req_i,
    input  logic [platform_pkg::ADDR_W-1:0]   addr_i,
    input  logic [platform_pkg::DATA_W-1:0]   rtc_rdata_i,
    input  logic [platform_pkg::DATA_W-1:0]   plic_rdata_i,
    input  logic [platform_pkg::DATA_W-1:0]   periph_rdata_i,
    output logic                              rtc_en_o,
    output logic                              plic_en_o,
    output logic                              periph_en_o,
    output logic [platform_pkg::DATA_W-1:0]   rdata_o
);

    platform_pkg::region_e region;
    platform_pkg::region_e region_q;   // region of last cycle's access
    logic [3:0]            nibble;

    assign nibble = addr_i[platform_pkg::ADDR_W-1 -: 4];

    ////////////////////
    // region decode
    always_comb begin
        if (nibble < platform_pkg::REGION_NONE_TOP) begin
            region = platform_pkg::NONE;
        end
        else if (nibble < platform_pkg::REGION_RTC_TOP) begin
            region = platform_pkg::RTC;
        end
        else if (nibble < platform_pkg::REGION_PLIC_TOP) begin
            region = platform_pkg::PLIC;
        end
        else begin
            region = platform_pkg::PERIPH;
        end
    end

    assign rtc_en_o    = req_i && (region == platform_pkg::RTC);
    assign plic_en_o   = req_i && (region == platform_pkg::PLIC);
    assign periph_en_o = req_i && (region == platform_pkg::PERIPH);

    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            region_q <= platform_pkg::NONE;
        end
        else begin
            region_q <= req_i ? region : platform_pkg::NONE;
        end
    end

    ////////////////////
    // read data mux, one cycle after the strobe
    always_comb begin
        case (region_q)
            platform_pkg::RTC:    rdata_o = rtc_rdata_i;
            platform_pkg::PLIC:   rdata_o = plic_rdata_i;
            platform_pkg::PERIPH: rdata_o = periph_rdata_i;
            default:              rdata_o = '0;   // unmapped reads as zero
        endcase
    end

    a_en_onehot: assert property (@(posedge clk) disable iff (!rst_n_i)
        $onehot0({rtc_en_o, plic_en_o, periph_en_o}))
        else $error("more than one slave enabled");

endmodule

// ==== verilog/mtimer.sv ====
module mtimer (
    input  logic                              clk,
    input  logic                              rst_n_i,
    input  logic                              en_i,
    input  logic [platform_pkg::BE_W-1:0]     we_i,
    input  logic [platform_pkg::OFFS_W-1:0]   addr_i,
    input  logic [platform_pkg::DATA_W-1:0]   wdata_i,
    output logic [platform_pkg::DATA_W-1:0]   rdata_o,
    output logic                              mti_o
);

    localparam int HALF = platform_pkg::DATA_W;

    logic [platform_pkg::MTIME_W-1:0] mtime;
    logic [platform_pkg::MTIME_W-1:0] mtimecmp;
    logic                             wr;

    assign wr = en_i && (we_i != '0);

    ////////////////////
    // free running counter
    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            mtime <= '0;
        end
        else begin
            mtime <= mtime + 1'b1;
        end
    end

    // compare register, byte writable halves
    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            mtimecmp <= '1;   // no interrupt until programmed
        end
        else if (wr) begin
            case (addr_i)
                platform_pkg::MT_CMP_LO: begin
                    mtimecmp[HALF-1:0] <=
                        platform_pkg::be_merge(mtimecmp[HALF-1:0], wdata_i, we_i);
                end
                platform_pkg::MT_CMP_HI: begin
                    mtimecmp[2*HALF-1:HALF] <=
                        platform_pkg::be_merge(mtimecmp[2*HALF-1:HALF], wdata_i, we_i);
                end
                default: ;   // mtime is read only
            endcase
        end
    end

    ////////////////////
    // read data, sampled at the strobe
    always_ff @(posedge clk) begin
        if (en_i) begin
            case (addr_i)
                platform_pkg::MT_MTIME_LO: rdata_o <= mtime[HALF-1:0];
                platform_pkg::MT_MTIME_HI: rdata_o <= mtime[2*HALF-1:HALF];
                platform_pkg::MT_CMP_LO:   rdata_o <= mtimecmp[HALF-1:0];
                default:                   rdata_o <= mtimecmp[2*HALF-1:HALF];
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            mti_o <= 1'b0;
        end
        else begin
            mti_o <= (mtime >= mtimecmp);
        end
    end

    a_mti_low: assert property (@(posedge clk) disable iff (!rst_n_i)
        (mtime < mtimecmp) |=> !mti_o)
        else $error("timer interrupt raised below compare value");

endmodule

// ==== verilog/plic_core.sv ====
module plic_core (
    input  logic                                clk,
    input  logic                                rst_n_i,
    input  logic                                en_i,
    input  logic [platform_pkg::BE_W-1:0]       we_i,
    input  logic [platform_pkg::OFFS_W-1:0]     addr_i,
    input  logic [platform_pkg::DATA_W-1:0]     wdata_i,
    input  logic [platform_pkg::IRQ_COUNT:1]    irq_req_i,
    output logic [platform_pkg::DATA_W-1:0]     rdata_o,
    output logic [platform_pkg::IRQ_COUNT:1]    iack_o,
    output logic                                meip_o
);

    localparam int N = platform_pkg::IRQ_COUNT;

    logic [N:1]                        pending;
    logic [N:1]                        enable;
    logic [N:1]                        in_service;   // claimed, not yet completed
    logic [N:1]                        active;
    logic [N:1]                        claim_mask;
    logic [N:1]                        done_mask;
    logic [N:1]                        take;
    logic [N:1]                        finish;
    logic [platform_pkg::IRQ_ID_W-1:0] claim_id;
    logic [platform_pkg::IRQ_ID_W-1:0] done_id;
    logic                              rd;
    logic                              wr;

    assign rd = en_i && (we_i == '0);
    assign wr = en_i && (we_i != '0);

    assign active = pending & enable;
    assign meip_o = |active;

    ////////////////////
    // claim arbitration, lowest id wins
    always_comb begin
        claim_id   = '0;
        claim_mask = '0;
        for (int i = N; i >= 1; i--) begin
            if (active[i]) begin
                claim_id      = platform_pkg::IRQ_ID_W'(i);
                claim_mask    = '0;
                claim_mask[i] = 1'b1;
            end
        end
    end

    // complete target, only a source in service
    assign done_id = wdata_i[platform_pkg::IRQ_ID_W-1:0];

    always_comb begin
        for (int i = 1; i <= N; i++) begin
            done_mask[i] = (done_id == platform_pkg::IRQ_ID_W'(i)) && in_service[i];
        end
    end

    assign take   = (rd && addr_i == platform_pkg::PL_CLAIM) ? claim_mask : '0;
    assign finish = (wr && addr_i == platform_pkg::PL_CLAIM) ? done_mask : '0;

    ////////////////////
    // gateway state
    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            pending    <= '0;
            in_service <= '0;
            iack_o     <= '0;
        end
        else begin
            pending    <= (pending & ~take) | (irq_req_i & ~pending & ~in_service);
            in_service <= (in_service | take) & ~iack_o;   // service ends with the ack
            iack_o     <= finish;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            enable <= '0;
        end
        else if (wr && we_i[0] && addr_i == platform_pkg::PL_ENABLE) begin
            enable <= wdata_i[N:1];
        end
    end

    // register bit position equals source id
    always_ff @(posedge clk) begin
        if (en_i) begin
            rdata_o <= '0;
            case (addr_i)
                platform_pkg::PL_PENDING: rdata_o[N:1] <= pending;
                platform_pkg::PL_ENABLE:  rdata_o[N:1] <= enable;
                platform_pkg::PL_CLAIM:   rdata_o      <= platform_pkg::DATA_W'(claim_id);
                default: ;
            endcase
        end
    end

    a_iack_onehot: assert property (@(posedge clk) disable iff (!rst_n_i)
        $onehot0(iack_o))
        else $error("more than one source acknowledged");

endmodule

// ==== verilog/event_periph.sv ====
module event_periph (
    input  logic                                clk,
    input  logic                                rst_n_i,
    input  logic                                en_i,
    input  logic [platform_pkg::BE_W-1:0]       we_i,
    input  logic [platform_pkg::OFFS_W-1:0]     addr_i,
    input  logic [platform_pkg::DATA_W-1:0]     wdata_i,
    input  logic                                btn_i,
    input  logic [platform_pkg::IRQ_COUNT:1]    iack_i,
    output logic [platform_pkg::DATA_W-1:0]     rdata_o,
    output logic [platform_pkg::IRQ_COUNT:1]    irq_req_o
);

    logic [2:0]                          btn_sync;   // two sync stages, then previous
    logic                                btn_rise;
    logic [platform_pkg::DATA_W-1:0]     count;
    logic [platform_pkg::DATA_W-1:0]     scratch;
    logic [platform_pkg::IRQ_COUNT:1]    raise;
    logic                                wr;

    assign wr = en_i && (we_i != '0);

    ////////////////////
    // button edge detect
    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            btn_sync <= '0;
            count    <= '0;
        end
        else begin
            btn_sync <= {btn_sync[1:0], btn_i};
            if (btn_rise) begin
                count <= count + 1'b1;
            end
        end
    end

    assign btn_rise = btn_sync[1] && !btn_sync[2];

    always_comb begin
        raise                            = '0;
        raise[platform_pkg::IRQ_SRC_BTN] = btn_rise;
        raise[platform_pkg::IRQ_SRC_SW]  = wr && we_i[0] && wdata_i[0] &&
                                           (addr_i == platform_pkg::EV_SWIRQ);
    end

    // a new event wins over an ack in the same cycle
    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            irq_req_o <= '0;
            scratch   <= '0;
        end
        else begin
            irq_req_o <= (irq_req_o & ~iack_i) | raise;
            if (wr && addr_i == platform_pkg::EV_SCRATCH) begin
                scratch <= platform_pkg::be_merge(scratch, wdata_i, we_i);
            end
        end
    end

    always_ff @(posedge clk) begin
        if (en_i) begin
            case (addr_i)
                platform_pkg::EV_COUNT:   rdata_o <= count;
                platform_pkg::EV_SCRATCH: rdata_o <= scratch;
                platform_pkg::EV_SWIRQ:   rdata_o <= {{(platform_pkg::DATA_W-1){1'b0}},
                                                      irq_req_o[platform_pkg::IRQ_SRC_SW]};
                default:                  rdata_o <= '0;
            endcase
        end
    end

    for (genvar g = 1; g <= platform_pkg::IRQ_COUNT; g++) begin : g_req_chk
        a_req_held: assert property (@(posedge clk) disable iff (!rst_n_i)
            $fell(irq_req_o[g]) |-> $past(iack_i[g]))
            else $error("request %0d dropped without ack", g);
    end

endmodule

// ==== verilog/platform_top.sv ====
module platform_top (
    input  logic                              clk,
    input  logic                              rst_n_i,
    input  logic                              req_i,
    input  logic [platform_pkg::BE_W-1:0]     we_i,
    input  logic [platform_pkg::ADDR_W-1:0]   addr_i,
    input  logic [platform_pkg::DATA_W-1:0]   wdata_i,
    input  logic                              btn_i,
    output logic [platform_pkg::DATA_W-1:0]   rdata_o,
    output logic                              mti_o,
    output logic                              meip_o
);

    logic                              rtc_en;
    logic                              plic_en;
    logic                              periph_en;
    logic [platform_pkg::DATA_W-1:0]   rtc_rdata;
    logic [platform_pkg::DATA_W-1:0]   plic_rdata;
    logic [platform_pkg::DATA_W-1:0]   periph_rdata;
    logic [platform_pkg::IRQ_COUNT:1]  irq_req;   // peripheral to plic
    logic [platform_pkg::IRQ_COUNT:1]  iack;      // plic back to peripheral

    ////////////////////
    // address decode and read mux
    bus_decoder i_decoder (
        .clk            (clk),
        .rst_n_i        (rst_n_i),
        .req_i          (req_i),
        .addr_i         (addr_i),
        .rtc_rdata_i    (rtc_rdata),
        .plic_rdata_i   (plic_rdata),
        .periph_rdata_i (periph_rdata),
        .rtc_en_o       (rtc_en),
        .plic_en_o      (plic_en),
        .periph_en_o    (periph_en),
        .rdata_o        (rdata_o)
    );

    ////////////////////
    // slaves
    mtimer i_mtimer (
        .clk     (clk),
        .rst_n_i (rst_n_i),
        .en_i    (rtc_en),
        .we_i    (we_i),
        .addr_i  (addr_i[platform_pkg::OFFS_W-1:0]),
        .wdata_i (wdata_i),
        .rdata_o (rtc_rdata),
        .mti_o   (mti_o)
    );

    plic_core i_plic (
        .clk       (clk),
        .rst_n_i   (rst_n_i),
        .en_i      (plic_en),
        .we_i      (we_i),
        .addr_i    (addr_i[platform_pkg::OFFS_W-1:0]),
        .wdata_i   (wdata_i),
        .irq_req_i (irq_req),
        .rdata_o   (plic_rdata),
        .iack_o    (iack),
        .meip_o    (meip_o)
    );

    event_periph i_periph (
        .clk       (clk),
        .rst_n_i   (rst_n_i),
        .en_i      (periph_en),
        .we_i      (we_i),
        .addr_i    (addr_i[platform_pkg::OFFS_W-1:0]),
        .wdata_i   (wdata_i),
        .btn_i     (btn_i),
        .iack_i    (iack),
        .rdata_o   (periph_rdata),
        .irq_req_o (irq_req)
    );

endmodule

// ==== tests/platform_tb.sv ====
module platform_tb;

    timeunit 1ns;
    timeprecision 1ps;

    localparam int OP_COUNT    = 300;   // rough number of bus operations and waits
    localparam int WDOG_CYCLES = OP_COUNT * 16;
    localparam int SCRATCH_OPS = 20;

    logic                            clk;
    logic                            rst_n_i;
    logic                            req_i;
    logic [platform_pkg::BE_W-1:0]   we_i;
    logic [platform_pkg::ADDR_W-1:0] addr_i;
    logic [platform_pkg::DATA_W-1:0] wdata_i;
    logic                            btn_i;
    logic [platform_pkg::DATA_W-1:0] rdata_o;
    logic                            mti_o;
    logic                            meip_o;

    // register model, updated by the testbench's own writes
    logic [31:0] m_scratch;
    logic [31:0] m_cmp_lo;
    logic [31:0] m_cmp_hi;
    logic [2:0]  m_enable;   // bit position equals source id
    logic [2:0]  m_pending;
    logic [31:0] m_count;

    logic [31:0] exp_q[$];
    bit          chk_q[$];
    string       name_q[$];
    logic        rd_seen;
    logic [31:0] last_rdata;
    int          err_count;

    platform_top i_dut (
        .clk     (clk),
        .rst_n_i (rst_n_i),
        .req_i   (req_i),
        .we_i    (we_i),
        .addr_i  (addr_i),
        .wdata_i (wdata_i),
        .btn_i   (btn_i),
        .rdata_o (rdata_o),
        .mti_o   (mti_o),
        .meip_o  (meip_o)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    // byte lanes selected by be take the new data
    function automatic logic [31:0] merge_lanes(input logic [31:0] old_w,
                                                input logic [31:0] new_w,
                                                input logic [3:0]  be);
        logic [31:0] mask;
        mask = {{8{be[3]}}, {8{be[2]}}, {8{be[1]}}, {8{be[0]}}};
        return (new_w & mask) | (old_w & ~mask);
    endfunction

    ////////////////////
    // expected read data from the model
    function automatic logic [31:0] ref_read(input logic [31:0] addr);
        logic [3:0]  nib;
        logic [3:0]  offs;
        logic [2:0]  act;
        logic [31:0] res;
        nib  = addr[31:28];
        offs = addr[3:0];
        act  = m_pending & m_enable;
        res  = '0;
        if (nib == 4'h2) begin
            if (offs == 4'h8) res = m_cmp_lo;
            else if (offs == 4'hC) res = m_cmp_hi;
        end
        else if (nib >= 4'h3 && nib < 4'h8) begin
            if (offs == 4'h0) res = {29'd0, m_pending};
            else if (offs == 4'h4) res = {29'd0, m_enable};
            else if (offs == 4'h8) res = act[1] ? 32'd1 : (act[2] ? 32'd2 : 32'd0);
        end
        else if (nib >= 4'h8) begin
            if (offs == 4'h0) res = m_count;
            else if (offs == 4'h4) res = m_scratch;
        end
        return res;   // ram region below 2 reads zero
    endfunction

    task automatic check(input string name, input logic [63:0] got, input logic [63:0] exp);
        if (got !== exp) begin
            err_count++;
            $display("ERR %s got=%h exp=%h", name, got, exp);
            $display("Some tests failed");
            $fatal(1);
        end
    endtask

    task automatic bus_write(input logic [31:0] addr, input logic [31:0] data,
                             input logic [3:0] be);
        @(posedge clk);
        req_i   <= 1'b1;
        we_i    <= be;
        addr_i  <= addr;
        wdata_i <= data;
        @(posedge clk);
        req_i <= 1'b0;
        we_i  <= '0;
        if (addr[31:28] == 4'h2 && addr[3:0] == 4'h8) begin
            m_cmp_lo = merge_lanes(m_cmp_lo, data, be);
        end
        if (addr[31:28] == 4'h2 && addr[3:0] == 4'hC) begin
            m_cmp_hi = merge_lanes(m_cmp_hi, data, be);
        end
        if (addr[31:28] >= 4'h8 && addr[3:0] == 4'h4) begin
            m_scratch = merge_lanes(m_scratch, data, be);
        end
        if (addr[31:28] == 4'h3 && addr[3:0] == 4'h4 && be[0]) begin
            m_enable = {data[2:1], 1'b0};
        end
    endtask

    task automatic bus_read(input logic [31:0] addr, input bit do_check, input string name,
                            output logic [31:0] data);
        logic [31:0] exp;
        exp = ref_read(addr);
        exp_q.push_back(exp);
        chk_q.push_back(do_check);
        name_q.push_back(name);
        if (addr[31:28] == 4'h3 && addr[3:0] == 4'h8 && exp != 0) begin
            m_pending[exp[1:0]] = 1'b0;   // claim moves the source to service
        end
        @(posedge clk);
        req_i  <= 1'b1;
        we_i   <= '0;
        addr_i <= addr;
        @(posedge clk);
        req_i <= 1'b0;
        @(negedge clk);
        #1;
        data = last_rdata;
    endtask

    // waits for an interrupt line to reach a level
    task automatic wait_irq(input string what, input bit use_mti, input logic val);
        int n;
        n = 0;
        @(negedge clk);
        while ((use_mti ? mti_o : meip_o) !== val) begin
            n++;
            if (n > 200) begin
                $display("%s did not reach %0d in time", what, val);
                $display("Some tests failed");
                $fatal(1);
            end
            @(negedge clk);
        end
    endtask

    ////////////////////
    // compare process
    always @(posedge clk) begin
        rd_seen <= req_i && (we_i == '0);
    end

    always @(negedge clk) begin
        logic [31:0] e;
        bit          c;
        string       nm;
        if (rd_seen) begin
            last_rdata = rdata_o;
            e  = exp_q.pop_front();
            c  = chk_q.pop_front();
            nm = name_q.pop_front();
            if (c) check(nm, 64'(rdata_o), 64'(e));
        end
    end

    initial begin
        repeat (WDOG_CYCLES) @(posedge clk);
        $display("watchdog expired after %0d cycles, test did not finish", WDOG_CYCLES);
        $display("Some tests failed");
        $fatal(1);
    end

    ////////////////////
    // stimulus
    initial begin
        logic [31:0] d;
        logic [31:0] t0;
        logic [31:0] t1;
        int          n;
        int          tries;
        void'($urandom(32'hf5d2));
        rst_n_i = 1'b0;
        req_i = 1'b0;
        we_i = '0;
        addr_i = '0;
        wdata_i = '0;
        btn_i = 1'b0;
        rd_seen = 1'b0;
        err_count = 0;
        m_scratch = '0;
        m_cmp_lo = '1;
        m_cmp_hi = '1;
        m_enable = '0;
        m_pending = '0;
        m_count = '0;
        repeat (2) @(posedge clk);
        rst_n_i <= 1'b1;

        // scratch merge and unmapped region
        for (int i = 0; i < SCRATCH_OPS; i++) begin
            // a zero byte enable is a read on this bus
            bus_write(32'h8000_0004, $urandom, 4'(1 + $urandom % 15));
            bus_read(32'h8000_0004, 1, "scratch", d);
        end
        for (int i = 0; i < 8; i++) begin
            bus_read($urandom & 32'h1fff_fffc, 1, "ram_region", d);
        end

        // timer
        bus_read(32'h2000_0000, 0, "mtime_lo", t0);
        repeat (5) @(posedge clk);
        bus_read(32'h2000_0000, 0, "mtime_lo", t1);
        check("mtime_delta", 64'(t1 - t0), 64'd7);   // strobes 7 cycles apart
        bus_write(32'h2000_000C, $urandom | 32'h8000_0000, 4'hf);
        bus_write(32'h2000_0008, $urandom, 4'hf);
        bus_read(32'h2000_000C, 1, "mtimecmp_hi", d);
        bus_read(32'h2000_0008, 1, "mtimecmp_lo", d);
        bus_write(32'h2000_000C, 32'd0, 4'hf);
        bus_read(32'h2000_0000, 0, "mtime_lo", t0);
        bus_write(32'h2000_0008, t0 + 40, 4'hf);
        repeat (20) @(negedge clk);   // still well below the compare count
        check("mti_o", 64'(mti_o), 64'd0);
        wait_irq("mti_o", 1, 1'b1);
        bus_read(32'h2000_0000, 0, "mtime_lo", t1);
        check("mtime_past_cmp", 64'(t1 >= t0 + 40), 64'd1);
        bus_write(32'h2000_0008, 32'hffff_ffff, 4'hf);
        bus_write(32'h2000_000C, 32'hffff_ffff, 4'hf);
        wait_irq("mti_o", 1, 1'b0);

        // software interrupt
        bus_write(32'h3000_0004, 32'h4, 4'hf);
        bus_read(32'h3000_0004, 1, "plic_enable", d);
        bus_write(32'h8000_0008, 32'h1, 4'hf);
        wait_irq("meip_o", 0, 1'b1);
        m_pending[2] = 1'b1;
        bus_read(32'h3000_0000, 1, "plic_pending", d);
        bus_read(32'h3000_0008, 1, "plic_claim", d);
        check("claim_id", 64'(d), 64'd2);
        check("meip_o", 64'(meip_o), 64'd0);
        bus_write(32'h3000_0008, 32'd2, 4'hf);
        repeat (4) @(posedge clk);
        bus_read(32'h3000_0000, 1, "plic_pending", d);

        // button pulses
        bus_write(32'h3000_0004, 32'h2, 4'hf);
        n = 3 + ($urandom % 4);
        for (int i = 0; i < n; i++) begin
            btn_i <= 1'b1;
            repeat (4 + ($urandom % 3)) @(posedge clk);
            btn_i <= 1'b0;
            repeat (4 + ($urandom % 3)) @(posedge clk);
        end
        m_count = m_count + n;
        tries = 0;
        bus_read(32'h8000_0000, 0, "count", d);
        while (d != m_count) begin
            tries++;
            if (tries > 20) begin
                $display("button count never reached %0d", m_count);
                $display("Some tests failed");
                $fatal(1);
            end
            bus_read(32'h8000_0000, 0, "count", d);
        end
        bus_read(32'h8000_0000, 1, "ev_count", d);
        wait_irq("meip_o", 0, 1'b1);
        m_pending[1] = 1'b1;
        bus_read(32'h3000_0008, 1, "plic_claim", d);
        check("claim_id", 64'(d), 64'd1);
        bus_write(32'h3000_0008, 32'd1, 4'hf);
        repeat (4) @(posedge clk);

        // masking and lowest id
        bus_write(32'h8000_0008, 32'h1, 4'hf);
        repeat (4) @(posedge clk);
        m_pending[2] = 1'b1;
        bus_read(32'h3000_0000, 1, "plic_pending", d);
        check("meip_o", 64'(meip_o), 64'd0);
        btn_i <= 1'b1;
        repeat (5) @(posedge clk);
        btn_i <= 1'b0;
        wait_irq("meip_o", 0, 1'b1);
        m_pending[1] = 1'b1;
        m_count = m_count + 1;
        bus_write(32'h3000_0004, 32'h6, 4'hf);
        bus_read(32'h3000_0000, 1, "plic_pending", d);
        bus_read(32'h3000_0008, 1, "plic_claim", d);
        check("first_claim", 64'(d), 64'd1);
        bus_read(32'h3000_0008, 1, "plic_claim", d);
        check("second_claim", 64'(d), 64'd2);
        bus_write(32'h3000_0008, 32'd1, 4'hf);
        bus_write(32'h3000_0008, 32'd2, 4'hf);
        repeat (4) @(posedge clk);
        bus_read(32'h3000_0000, 1, "plic_pending", d);
        bus_read(32'h8000_0000, 1, "ev_count", d);

        if (err_count == 0) begin
            $display("All tests passed");
        end
        else begin
            $display("Some tests failed");
        end
        $finish;
    end

endmodule

// ==== sources.f ====
verilog/platform_pkg.sv
verilog/bus_decoder.sv
verilog/mtimer.sv
verilog/plic_core.sv
verilog/event_periph.sv
verilog/platform_top.sv
tests/platform_tb.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# build and run the platform testbench with Verilator
set -e

cd "$(dirname "$0")"

LOG=sim.log

verilator --binary --assert -j 0 \
    -f sources.f \
    --top-module platform_tb \
    -o platform_sim

./obj_dir/platform_sim > "$LOG" 2>&1 || true
cat "$LOG"

if grep -q "Some tests failed" "$LOG"; then
    echo "simulation FAILED"
    exit 1
fi

if ! grep -q "All tests passed" "$LOG"; then
    echo "simulation ended without a result"
    exit 1
fi

echo "simulation passed"
